//--- all.f
+incdir+verilog
verilog/video_pkg.sv
verilog/bus_pkg.sv
verilog/video_timing.sv
verilog/apb_regs.sv
verilog/tile_layer.sv
verilog/color_mixer.sv
verilog/video_top.sv
verif/tb_video_top.sv

//--- Makefile
# Verilator build and run for the video subsystem testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert -f all.f --top-module tb_video_top \
		-Mdir obj_dir -o sim_video
	./obj_dir/sim_video | tee $(LOG)
	@grep -q "^Done: no errors$$" $(LOG) && echo "PASS" || { echo "FAIL"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- verif/tb_video_top.sv
// Testbench for the video subsystem with APB traffic, a shadow model and pixel checks
`include "video_consts.svh"

module tb_video_top import video_pkg::*, bus_pkg::*; ();

    localparam int FRAME_CLKS   = `H_TOTAL * `V_TOTAL * 2;
    localparam int FRAME_BUDGET = 15;
    localparam int APB_CLKS     = 1000;
    localparam int MAX_CYCLES   = FRAME_BUDGET * FRAME_CLKS + APB_CLKS;
    localparam int CHECK_FRAMES = 5;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        irq_n;
    logic        hs;
    logic        vs;
    logic        lhbl_dly;
    logic        lvbl_dly;
    logic [4:0]  red;
    logic [4:0]  green;
    logic [4:0]  blue;

    // Shadow of everything the CPU has written
    logic [7:0]  map1_sh [0:`MAP_WORDS-1];
    logic [7:0]  map2_sh [0:`MAP_WORDS-1];
    logic [14:0] pal_sh  [0:`PAL_SIZE-1];
    logic [2:0]  ctrl_sh = '0;
    logic [4:0]  scroll1_sh = '0;
    logic [4:0]  scroll2_sh = '0;

    int          errors = 0;
    int          cycles = 0;
    int          pixels_checked = 0;
    string       test_name = "reset";
    logic        check_en = 1'b0;
    logic [14:0] exp_rgb;

    // Raster position recovered from the delayed blanking outputs
    int   px_x = 0;
    int   px_y = 0;
    int   hbl_len = 0;
    int   hs_cnt = 0;
    int   vs_cnt = 0;
    logic hbl_q = 1'b0;
    logic vbl_q = 1'b0;
    logic hs_q = 1'b0;
    logic vs_q = 1'b0;
    logic line_seen = 1'b0;
    logic frame_seen = 1'b0;

    video_top UUT (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .irq_n(irq_n), .hs(hs), .vs(vs), .lhbl_dly(lhbl_dly),
        .lvbl_dly(lvbl_dly), .red(red), .green(green), .blue(blue)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("error %s: expected %0h, actual %0h", name, exp, act);
    endtask

    function automatic region_t region_of(input logic [7:0] addr);
        int a;
        a = int'(addr);
        if (a <= int'(`ADDR_IRQ_ACK)) return REG_CTRL;
        if (a >= int'(`ADDR_MAP1) && a < int'(`ADDR_MAP1) + `MAP_WORDS) return REG_MAP1;
        if (a >= int'(`ADDR_MAP2) && a < int'(`ADDR_MAP2) + `MAP_WORDS) return REG_MAP2;
        if (a >= int'(`ADDR_PAL) && a < int'(`ADDR_PAL) + `PAL_SIZE) return REG_PAL;
        return REG_NONE;
    endfunction

    function automatic logic [15:0] shadow_read(input logic [7:0] addr);
        case (region_of(addr))
            REG_MAP1: return {8'd0, map1_sh[addr[4:0]]};
            REG_MAP2: return {8'd0, map2_sh[addr[4:0]]};
            REG_PAL:  return {1'b0, pal_sh[addr[3:0]]};
            REG_CTRL: begin
                if (addr == `ADDR_CTRL) return {13'd0, ctrl_sh};
                if (addr == `ADDR_SCROLL1) return {11'd0, scroll1_sh};
                if (addr == `ADDR_SCROLL2) return {11'd0, scroll2_sh};
                return 16'd0;
            end
            default:  return 16'd0;
        endcase
    endfunction

    // Map word under screen pixel (x, y) for a given scroll
    function automatic logic [4:0] tile_addr(input int x, input int y, input logic [4:0] scroll);
        int col;
        int row;
        col = ((x + int'(scroll)) / `TILE_SIZE) % `MAP_COLS;
        row = (y / `TILE_SIZE) % `MAP_ROWS;
        return 5'(row * `MAP_COLS + col);
    endfunction

    function automatic logic [3:0] tile_index(input logic [7:0] entry);
        return entry[4] ? 4'd0 : entry[3:0];
    endfunction

    function automatic logic [14:0] expected_rgb(input int x, input int y);
        logic [3:0] i1;
        logic [3:0] i2;
        logic       on1;
        logic       on2;
        mix_src_t   src;
        i1 = tile_index(map1_sh[tile_addr(x, y, scroll1_sh)]);
        i2 = tile_index(map2_sh[tile_addr(x, y, scroll2_sh)]);
        on1 = ctrl_sh[0] && (i1 != 4'd0);
        on2 = ctrl_sh[1] && (i2 != 4'd0);
        src = SRC_BACK;
        // Bit 2 of the control word brings layer 2 to the front
        if (ctrl_sh[2]) begin
            if (on2) src = SRC_LAYER2;
            else if (on1) src = SRC_LAYER1;
        end else begin
            if (on1) src = SRC_LAYER1;
            else if (on2) src = SRC_LAYER2;
        end
        case (src)
            SRC_LAYER1: return pal_sh[i1];
            SRC_LAYER2: return pal_sh[i2];
            default:    return pal_sh[0];
        endcase
    endfunction

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [15:0] wdata,
                            output logic [15:0] rdata, output logic err, output int waits);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [15:0] data);
        logic [15:0] rd;
        logic        err;
        int          waits;
        region_t     target;
        target = region_of(addr);
        apb_xfer(1'b1, addr, data, rd, err, waits);
        assert (waits == 0) else report_mismatch("write_wait", 32'd0, 32'(waits));
        assert (err == (target == REG_NONE))
            else report_mismatch("write_slverr", 32'(target == REG_NONE), 32'(err));
        case (target)
            REG_CTRL: begin
                if (addr == `ADDR_CTRL) ctrl_sh = data[2:0];
                else if (addr == `ADDR_SCROLL1) scroll1_sh = data[4:0];
                else if (addr == `ADDR_SCROLL2) scroll2_sh = data[4:0];
            end
            REG_MAP1: map1_sh[addr[4:0]] = data[7:0];
            REG_MAP2: map2_sh[addr[4:0]] = data[7:0];
            REG_PAL:  pal_sh[addr[3:0]] = data[14:0];
            default:  ;
        endcase
    endtask

    task automatic apb_read_check(input logic [7:0] addr, input string name);
        logic [15:0] rd;
        logic        err;
        int          waits;
        logic        mapped;
        mapped = (region_of(addr) != REG_NONE);
        apb_xfer(1'b0, addr, 16'd0, rd, err, waits);
        assert (err == !mapped) else report_mismatch({name, "_slverr"}, 32'(!mapped), 32'(err));
        assert (waits == (mapped ? 1 : 0))
            else report_mismatch({name, "_wait"}, 32'(mapped), 32'(waits));
        if (mapped) begin
            assert (rd == shadow_read(addr))
                else report_mismatch(name, 32'(shadow_read(addr)), 32'(rd));
        end
    endtask

    // Waits out a full vblank after the last write and then checks one frame
    task automatic run_frame(input string name);
        test_name = name;
        @(negedge lvbl_dly);
        @(posedge lvbl_dly);
        check_en = 1'b1;
        @(negedge lvbl_dly);
        check_en = 1'b0;
    endtask

    task automatic irq_frame();
        int n;
        @(posedge lvbl_dly);
        apb_write(`ADDR_IRQ_ACK, 16'd0);
        assert (irq_n) else report_mismatch("irq_ack", 32'd1, 32'(irq_n));
        @(negedge irq_n);
        n = 0;
        // lvbl_dly trails the raw vblank by the 4-pixel pipeline
        while (lvbl_dly) begin
            @(negedge clk);
            n++;
        end
        assert (n >= 4 && n <= 12) else report_mismatch("irq_window", 32'd8, 32'(n));
        apb_write(`ADDR_IRQ_ACK, 16'd0);
        assert (irq_n) else report_mismatch("irq_ack", 32'd1, 32'(irq_n));
        @(posedge lvbl_dly);
        assert (irq_n) else report_mismatch("irq_once", 32'd1, 32'(irq_n));
    endtask

    assert property (@(posedge clk) disable iff (!rst_n) pslverr |-> pready)
        else begin
            errors++;
            $display("pslverr was raised without pready");
        end

    assert property (@(negedge clk) disable iff (!rst_n)
        !(lhbl_dly && lvbl_dly) |-> ({blue, green, red} == 15'd0))
        else report_mismatch("blank_zero", 32'd0, 32'({blue, green, red}));

    // Outputs settle on the clk edge that follows a high pxl_cen
    always @(negedge clk) begin
        if (rst_n && !UUT.pxl_cen) begin
            if (lhbl_dly && lvbl_dly) begin
                if (check_en) begin
                    exp_rgb = expected_rgb(px_x, px_y);
                    assert ({blue, green, red} == exp_rgb)
                        else report_mismatch(test_name, 32'(exp_rgb), 32'({blue, green, red}));
                    pixels_checked++;
                end
                px_x++;
            end
            if (lhbl_dly) hbl_len++;
            if (hs && !hs_q) hs_cnt++;
            if (vs && !vs_q) vs_cnt++;
            if (lhbl_dly && !hbl_q) begin
                if (line_seen) begin
                    assert (hs_cnt == 1)
                        else report_mismatch("hsync_count", 32'd1, 32'(hs_cnt));
                end
                hs_cnt = 0;
                line_seen = 1'b1;
            end
            if (!lhbl_dly && hbl_q) begin
                assert (hbl_len == `H_VISIBLE)
                    else report_mismatch("hblank_width", 32'(`H_VISIBLE), 32'(hbl_len));
                hbl_len = 0;
                px_x = 0;
                if (lvbl_dly) px_y++;
            end
            if (lvbl_dly && !vbl_q) begin
                if (frame_seen) begin
                    assert (vs_cnt == 1)
                        else report_mismatch("vsync_count", 32'd1, 32'(vs_cnt));
                end
                vs_cnt = 0;
                frame_seen = 1'b1;
            end
            if (!lvbl_dly && vbl_q) begin
                assert (px_y == `V_VISIBLE)
                    else report_mismatch("vblank_lines", 32'(`V_VISIBLE), 32'(px_y));
                px_y = 0;
            end
            hbl_q = lhbl_dly;
            vbl_q = lvbl_dly;
            hs_q  = hs;
            vs_q  = vs;
        end
    end

    initial begin
        void'($urandom(32'hb28));
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'd0;
        pwdata  = 16'd0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert ({irq_n, pready, pslverr, hs, vs, lhbl_dly, lvbl_dly, blue, green, red}
                == 22'h200000)
            else report_mismatch("reset_outputs", 32'h200000,
                32'({irq_n, pready, pslverr, hs, vs, lhbl_dly, lvbl_dly, blue, green, red}));
        apb_read_check(`ADDR_CTRL, "ctrl_reset");

        // Random palette and maps with both layers still off
        for (int i = 0; i < `PAL_SIZE; i++) begin
            apb_write(8'(int'(`ADDR_PAL) + i), 16'($urandom & 32'h7fff));
        end
        for (int i = 0; i < `MAP_WORDS; i++) begin
            apb_write(8'(int'(`ADDR_MAP1) + i), 16'($urandom & 32'hff));
            apb_write(8'(int'(`ADDR_MAP2) + i), 16'($urandom & 32'hff));
        end
        run_frame("background");

        apb_write(`ADDR_CTRL, 16'h0001);
        apb_write(`ADDR_SCROLL1, 16'h0003);
        run_frame("layer1_only");
        apb_write(`ADDR_CTRL, 16'h0003);
        run_frame("prio_clear");
        apb_write(`ADDR_CTRL, 16'h0007);
        run_frame("prio_set");
        apb_write(`ADDR_SCROLL2, 16'h0005);
        run_frame("scroll2_shift");

        apb_read_check(`ADDR_CTRL, "ctrl_read");
        apb_read_check(`ADDR_SCROLL1, "scroll1_read");
        apb_read_check(`ADDR_SCROLL2, "scroll2_read");
        apb_read_check(`ADDR_IRQ_ACK, "irq_ack_read");
        for (int i = 0; i < `PAL_SIZE; i++) begin
            apb_read_check(8'(int'(`ADDR_PAL) + i), "pal_read");
        end
        for (int i = 0; i < `MAP_WORDS; i++) begin
            apb_read_check(8'(int'(`ADDR_MAP1) + i), "map1_read");
            apb_read_check(8'(int'(`ADDR_MAP2) + i), "map2_read");
        end

        // Unmapped addresses share low address bits with the first palette and map words
        apb_write(8'h90, 16'h1234);
        apb_read_check(8'h90, "unmapped_read");
        apb_write(8'h20, 16'h00ff);
        apb_read_check(`ADDR_PAL, "pal_after_err");
        apb_read_check(`ADDR_MAP1, "map1_after_err");
        apb_read_check(`ADDR_MAP2, "map2_after_err");
        apb_read_check(`ADDR_CTRL, "ctrl_after_err");

        irq_frame();
        irq_frame();

        assert (pixels_checked == CHECK_FRAMES * `H_VISIBLE * `V_VISIBLE)
            else report_mismatch("pixel_count", 32'(CHECK_FRAMES * `H_VISIBLE * `V_VISIBLE),
                32'(pixels_checked));
        $display("Errors: %0d, pixels checked: %0d, cycles: %0d", errors, pixels_checked,
                 cycles);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog/video_top.sv
// Video subsystem top: timing, APB registers, two tile layers and colour mixer
module video_top import video_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // APB
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [15:0] pwdata,
    output logic [15:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        irq_n,
    // Video
    output logic        hs,
    output logic        vs,
    output logic        lhbl_dly,
    output logic        lvbl_dly,
    output logic [4:0]  red,
    output logic [4:0]  green,
    output logic [4:0]  blue
);

    logic        pxl_cen, lhbl, lvbl, vblank_start;
    logic [5:0]  hdump;
    logic [4:0]  vdump;
    logic        map1_we, map2_we, pal_we;
    logic [4:0]  wr_addr, rd_addr;
    logic [15:0] wr_data;
    logic [7:0]  map1_rdata, map2_rdata;
    rgb_t        pal_rdata;
    logic [4:0]  scroll1, scroll2;
    logic [1:0]  layer_en;
    logic        prio;
    pxl_idx_t    layer1_pxl, layer2_pxl;

    video_timing u_timing (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .hdump(hdump), .vdump(vdump),
        .lhbl(lhbl), .lvbl(lvbl), .hs(hs), .vs(vs), .vblank_start(vblank_start)
    );

    apb_regs u_regs (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .vblank_start(vblank_start), .map1_rdata(map1_rdata),
        .map2_rdata(map2_rdata), .pal_rdata(pal_rdata), .map1_we(map1_we),
        .map2_we(map2_we), .pal_we(pal_we), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr), .scroll1(scroll1), .scroll2(scroll2), .layer_en(layer_en),
        .prio(prio), .irq_n(irq_n)
    );

    // Map entries are 8 bits wide
    tile_layer u_layer1 (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .hdump(hdump), .vdump(vdump),
        .scroll(scroll1), .map_we(map1_we), .wr_addr(wr_addr), .wr_data(wr_data[7:0]),
        .rd_addr(rd_addr), .map_rdata(map1_rdata), .pxl(layer1_pxl)
    );

    tile_layer u_layer2 (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .hdump(hdump), .vdump(vdump),
        .scroll(scroll2), .map_we(map2_we), .wr_addr(wr_addr), .wr_data(wr_data[7:0]),
        .rd_addr(rd_addr), .map_rdata(map2_rdata), .pxl(layer2_pxl)
    );

    // Picks a mix_src_t per pixel and drives the colour outputs
    color_mixer u_mixer (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .lhbl(lhbl), .lvbl(lvbl),
        .layer_en(layer_en), .prio(prio), .layer1_pxl(layer1_pxl),
        .layer2_pxl(layer2_pxl), .pal_we(pal_we), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr), .pal_rdata(pal_rdata), .red(red), .green(green), .blue(blue),
        .lhbl_dly(lhbl_dly), .lvbl_dly(lvbl_dly)
    );

endmodule

//--- verilog/color_mixer.sv
// Colour mixer: layer priority, palette lookup, RGB output and blanking delay
`include "video_consts.svh"

module color_mixer import video_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pxl_cen,
    input  logic        lhbl,
    input  logic        lvbl,
    input  logic [1:0]  layer_en,
    input  logic        prio,
    input  pxl_idx_t    layer1_pxl,
    input  pxl_idx_t    layer2_pxl,
    input  logic        pal_we,
    input  logic [4:0]  wr_addr,
    input  logic [15:0] wr_data,
    input  logic [4:0]  rd_addr,
    output rgb_t        pal_rdata,
    output logic [4:0]  red,
    output logic [4:0]  green,
    output logic [4:0]  blue,
    output logic        lhbl_dly,
    output logic        lvbl_dly
);

    rgb_t       pal_mem [0:`PAL_SIZE-1];
    rgb_t       col_q;
    mix_src_t   src;
    pxl_idx_t   sel_idx;
    logic       front_en;
    logic       back_en;
    pxl_idx_t   front_pxl;
    pxl_idx_t   back_pxl;
    logic [3:0] hbl_sr;
    logic [3:0] vbl_sr;

    // prio set puts layer 2 in front
    assign front_pxl = prio ? layer2_pxl  : layer1_pxl;
    assign back_pxl  = prio ? layer1_pxl  : layer2_pxl;
    assign front_en  = prio ? layer_en[1] : layer_en[0];
    assign back_en   = prio ? layer_en[0] : layer_en[1];

    always_comb begin
        if (front_en && front_pxl != '0) begin
            src = prio ? SRC_LAYER2 : SRC_LAYER1;
        end else if (back_en && back_pxl != '0) begin
            src = prio ? SRC_LAYER1 : SRC_LAYER2;
        end else begin
            src = SRC_BACK;
        end
    end

    always_comb begin
        case (src)
            SRC_LAYER1: sel_idx = layer1_pxl;
            SRC_LAYER2: sel_idx = layer2_pxl;
            default:    sel_idx = '0;
        endcase
    end

    // Palette, CPU port only uses the low address bits
    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_mem[wr_addr[3:0]] <= rgb_t'(wr_data[14:0]);
        end
        pal_rdata <= pal_mem[rd_addr[3:0]];
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            col_q <= pal_mem[sel_idx];
        end
    end

    // Blanking follows the pixel through all four stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hbl_sr <= '0;
            vbl_sr <= '0;
        end else if (pxl_cen) begin
            hbl_sr <= {hbl_sr[2:0], lhbl};
            vbl_sr <= {vbl_sr[2:0], lvbl};
        end
    end

    assign lhbl_dly = hbl_sr[3];
    assign lvbl_dly = vbl_sr[3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            if (hbl_sr[2] && vbl_sr[2]) begin
                red   <= col_q.red;
                green <= col_q.green;
                blue  <= col_q.blue;
            end else begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

//--- verilog/tile_layer.sv
// Tile layer: tile map RAM with CPU port, horizontal scroll and two-stage pixel fetch
`include "video_consts.svh"

module tile_layer import video_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  logic [5:0] hdump,
    input  logic [4:0] vdump,
    input  logic [4:0] scroll,
    input  logic       map_we,
    input  logic [4:0] wr_addr,
    input  logic [7:0] wr_data,
    input  logic [4:0] rd_addr,
    output logic [7:0] map_rdata,
    output pxl_idx_t   pxl
);

    localparam int TILE_BITS = $clog2(`TILE_SIZE);
    localparam int COL_BITS  = $clog2(`MAP_COLS);
    localparam int ROW_BITS  = $clog2(`MAP_ROWS);

    // Entry layout: [3:0] colour index, [4] force transparent
    logic [7:0]          map_mem [0:`MAP_WORDS-1];
    logic [5:0]          scr_x;
    logic [COL_BITS-1:0] col;
    logic [ROW_BITS-1:0] row;
    logic [4:0]          map_addr;
    logic [7:0]          tile_q;

    // Scroll is in pixels, map wraps after MAP_COLS tiles
    assign scr_x    = hdump + {1'b0, scroll};
    assign col      = scr_x[TILE_BITS +: COL_BITS];
    assign row      = vdump[TILE_BITS +: ROW_BITS];
    assign map_addr = {row, col};

    // CPU side
    always_ff @(posedge clk) begin
        if (map_we) begin
            map_mem[wr_addr] <= wr_data;
        end
        map_rdata <= map_mem[rd_addr];
    end

    // Stage 1: map read for the current position
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            tile_q <= map_mem[map_addr];
        end
    end

    // Stage 2: transparency and output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            if (tile_q[4]) begin
                pxl <= '0;
            end else begin
                pxl <= pxl_idx_t'(tile_q[3:0]);
            end
        end
    end

endmodule

//--- verilog/apb_regs.sv
// APB register block: address decode, write strobes, control registers, read-back and IRQ
`include "video_consts.svh"

module apb_regs import video_pkg::*, bus_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [15:0] pwdata,
    output logic [15:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        vblank_start,
    input  logic [7:0]  map1_rdata,
    input  logic [7:0]  map2_rdata,
    input  rgb_t        pal_rdata,
    output logic        map1_we,
    output logic        map2_we,
    output logic        pal_we,
    output logic [4:0]  wr_addr,
    output logic [15:0] wr_data,
    output logic [4:0]  rd_addr,
    output logic [4:0]  scroll1,
    output logic [4:0]  scroll2,
    output logic [1:0]  layer_en,
    output logic        prio,
    output logic        irq_n
);

    apb_state_t state;
    apb_state_t next;
    region_t    region;
    logic       access;
    logic       wr_stb;

    always_comb begin
        if (paddr <= `ADDR_IRQ_ACK) region = REG_CTRL;
        else if (paddr >= `ADDR_MAP1 && paddr < `ADDR_MAP2) region = REG_MAP1;
        else if (paddr >= `ADDR_MAP2 && paddr < `ADDR_PAL) region = REG_MAP2;
        else if (paddr >= `ADDR_PAL && (paddr - `ADDR_PAL) < 8'(`PAL_SIZE)) region = REG_PAL;
        else region = REG_NONE;
    end

    always_comb begin
        next = state;
        case (state)
            APB_IDLE:   if (psel && !penable) next = APB_ACCESS;
            APB_ACCESS: next = (!pwrite && region != REG_NONE) ? APB_WAIT : APB_IDLE;
            default:    next = APB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= APB_IDLE;
        end else begin
            state <= next;
        end
    end

    assign access  = (state == APB_ACCESS) && psel && penable;
    assign pslverr = access && (region == REG_NONE);
    // Writes and errors finish in the first access cycle, reads one later
    assign pready  = (access && (pwrite || region == REG_NONE)) || (state == APB_WAIT);
    assign wr_stb  = access && pwrite;

    assign map1_we = wr_stb && (region == REG_MAP1);
    assign map2_we = wr_stb && (region == REG_MAP2);
    assign pal_we  = wr_stb && (region == REG_PAL);
    assign wr_addr = paddr[4:0];
    assign wr_data = pwdata;
    // RAMs register the read, so data is ready in the wait cycle
    assign rd_addr = paddr[4:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_en <= '0;
            prio     <= 1'b0;
            scroll1  <= '0;
            scroll2  <= '0;
            irq_n    <= 1'b1;
        end else begin
            if (wr_stb && paddr == `ADDR_CTRL) begin
                layer_en <= pwdata[1:0];
                prio     <= pwdata[2];
            end
            if (wr_stb && paddr == `ADDR_SCROLL1) scroll1 <= pwdata[4:0];
            if (wr_stb && paddr == `ADDR_SCROLL2) scroll2 <= pwdata[4:0];
            // New vblank wins over an acknowledge in the same cycle
            if (vblank_start) irq_n <= 1'b0;
            else if (wr_stb && paddr == `ADDR_IRQ_ACK) irq_n <= 1'b1;
        end
    end

    always_comb begin
        prdata = '0;
        if (state == APB_WAIT) begin
            case (region)
                REG_CTRL: begin
                    case (paddr)
                        `ADDR_CTRL:    prdata = {13'd0, prio, layer_en};
                        `ADDR_SCROLL1: prdata = {11'd0, scroll1};
                        `ADDR_SCROLL2: prdata = {11'd0, scroll2};
                        default:       prdata = '0;
                    endcase
                end
                REG_MAP1: prdata = {8'd0, map1_rdata};
                REG_MAP2: prdata = {8'd0, map2_rdata};
                REG_PAL:  prdata = {1'b0, pal_rdata};
                default:  prdata = '0;
            endcase
        end
    end

endmodule

//--- verilog/video_timing.sv
// Video timing generator: pixel enable, raster counters, blanking, syncs and vblank start
`include "video_consts.svh"

module video_timing (
    input  logic       clk,
    input  logic       rst_n,
    output logic       pxl_cen,
    output logic [5:0] hdump,
    output logic [4:0] vdump,
    output logic       lhbl,
    output logic       lvbl,
    output logic       hs,
    output logic       vs,
    output logic       vblank_start
);

    logic cen_q;
    logic lvbl_q;
    logic h_last;
    logic v_last;

    // Pixel rate is half of clk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_q <= 1'b0;
        end else begin
            cen_q <= ~cen_q;
        end
    end

    assign pxl_cen = cen_q;

    assign h_last = (hdump == 6'(`H_TOTAL - 1));
    assign v_last = (vdump == 5'(`V_TOTAL - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            hdump <= h_last ? '0 : hdump + 6'd1;
            if (h_last) begin
                vdump <= v_last ? '0 : vdump + 5'd1;
            end
        end
    end

    assign lhbl = (hdump < 6'(`H_VISIBLE));
    assign lvbl = (vdump < 5'(`V_VISIBLE));

    assign hs = (hdump >= 6'(`H_SYNC_START)) &&
                (hdump <  6'(`H_SYNC_START + `H_SYNC_WIDTH));
    assign vs = (vdump >= 5'(`V_SYNC_START)) &&
                (vdump <  5'(`V_SYNC_START + `V_SYNC_WIDTH));

    // Falling edge of lvbl, one clk wide
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lvbl_q <= 1'b0;
        end else begin
            lvbl_q <= lvbl;
        end
    end

    assign vblank_start = lvbl_q & ~lvbl;

endmodule

//--- verilog/bus_pkg.sv
// Bus package: APB slave phases and decoded register regions
package bus_pkg;

    // Slave phase, WAIT only used by reads
    typedef enum logic [1:0] {
        APB_IDLE   = 2'd0,
        APB_ACCESS = 2'd1,
        APB_WAIT   = 2'd2
    } apb_state_t;

    // Target of the current address
    typedef enum logic [2:0] {
        REG_CTRL = 3'd0,
        REG_MAP1 = 3'd1,
        REG_MAP2 = 3'd2,
        REG_PAL  = 3'd3,
        REG_NONE = 3'd4
    } region_t;

endpackage

//--- verilog/video_pkg.sv
// Video package: pixel index, palette word and mixer source types
package video_pkg;

    // Colour index from a tile layer, 0 is transparent
    typedef logic [3:0] pxl_idx_t;

    // RGB555 palette word, red in the low bits
    typedef struct packed {
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } rgb_t;

    // Which source wins a pixel in the mixer
    typedef enum logic [1:0] {
        SRC_BACK   = 2'd0,
        SRC_LAYER1 = 2'd1,
        SRC_LAYER2 = 2'd2
    } mix_src_t;

endpackage

//--- verilog/video_consts.svh
// Video constants: screen geometry, tile and map sizes, palette size and APB address map
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// Raster, counted in pixels and lines
`define H_TOTAL       48
`define H_VISIBLE     32
`define V_TOTAL       20
`define V_VISIBLE     16
`define H_SYNC_START  36
`define H_SYNC_WIDTH  4
`define V_SYNC_START  17
`define V_SYNC_WIDTH  1

// Tile geometry
`define TILE_SIZE     8
`define MAP_COLS      8
`define MAP_ROWS      4
`define MAP_WORDS     (`MAP_COLS * `MAP_ROWS)
`define PAL_SIZE      16

// APB register and memory map
`define ADDR_CTRL     8'h00
`define ADDR_SCROLL1  8'h01
`define ADDR_SCROLL2  8'h02
`define ADDR_IRQ_ACK  8'h03
`define ADDR_MAP1     8'h40
`define ADDR_MAP2     8'h60
`define ADDR_PAL      8'h80

`endif
